/* Bender.yml */
package:
  name: bpu

export_include_dirs:
  - include

sources:
  - src/bpu_pkg.sv
  - src/bpu_table.sv
  - src/bpu_update_decode.sv
  - src/bpu_ras.sv
  - src/bpu_next_pc.sv
  - src/bpu_top.sv
  - target: simulation
    files:
      - verif/bpu_tb.sv

/* files.f */
+incdir+include
src/bpu_pkg.sv
src/bpu_table.sv
src/bpu_update_decode.sv
src/bpu_ras.sv
src/bpu_next_pc.sv
src/bpu_top.sv
verif/bpu_tb.sv

/* include/bpu_config.svh */
`ifndef BPU_CONFIG_SVH
`define BPU_CONFIG_SVH

// fetch pc after reset
`define BPU_INIT_PC 32'h1c00_0000

// btb and bht share index width and depth
`define BPU_BTB_LEN 9
`define BPU_BTB_DEPTH 512

// tag comes from pc bits starting at bit 12
`define BPU_TAG_LEN 8

// local history per bht entry
`define BPU_HISTORY_LEN 5

// pht index = {history, pc[10:3]}
`define BPU_PHT_PC_LEN 8
`define BPU_PHT_LEN 13
`define BPU_PHT_DEPTH 8192

// return address stack
`define BPU_RAS_LEN 3
`define BPU_RAS_DEPTH 8

`endif

/* src/bpu_next_pc.sv */
`timescale 1ns/1ps

`include "bpu_config.svh"

module bpu_next_pc (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 flush_i,
    input  logic [31:0]                          redir_addr_i,
    input  bpu_pkg::btb_entry_t [1:0]            btb_rdata_i,
    input  bpu_pkg::bht_entry_t [1:0]            bht_rdata_i,
    input  bpu_pkg::pht_entry_t [1:0]            pht_rdata_i,
    input  logic [31:0]                          ras_top_i,
    output logic [`BPU_BTB_LEN-1:0]              btb_raddr_o, // also the bht index
    output logic [1:0][`BPU_PHT_LEN-1:0]         pht_raddr_o,
    output logic                                 pkt_valid_o,
    output bpu_pkg::fetch_pkt_t                  pkt_o,
    input  logic                                 pkt_ready_i
);

    import bpu_pkg::*;

    logic [31:0]       pc_q;
    logic              valid_q;   // out of reset
    logic [31:0]       pc_seq;    // next aligned packet
    logic [31:0]       pc_next;
    logic [1:0]        tag_match;
    logic [1:0]        taken;
    logic [1:0]        mask;
    logic [1:0][31:0]  target;
    logic [1:0][31:0]  slot_next; // fall-through or target per slot

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q    <= `BPU_INIT_PC;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;
            if (flush_i) begin
                pc_q <= redir_addr_i; // flush beats back-pressure
            end else if (valid_q && pkt_ready_i) begin
                pc_q <= pc_next;
            end
        end
    end

    assign btb_raddr_o = btb_hash(pc_q);
    assign pc_seq      = {pc_q[31:3] + 29'd1, 3'b000};

    for (genvar i = 0; i < 2; i++) begin : g_slot
        assign tag_match[i]   = btb_rdata_i[i].tag == pc_tag(pc_q);
        // jumps always taken, conditionals follow the counter msb
        assign taken[i]       = btb_rdata_i[i].is_branch & tag_match[i]
                              & ((btb_rdata_i[i].br_type != BR_NORMAL) | pht_rdata_i[i].scnt[1]);
        assign target[i]      = (btb_rdata_i[i].br_type == BR_RET) ? ras_top_i
                                                                   : btb_rdata_i[i].target_pc;
        assign pht_raddr_o[i] = {bht_rdata_i[i].history, pc_q[`BPU_PHT_PC_LEN+2:3]};
    end

    assign slot_next[0] = taken[0] ? target[0] : {pc_q[31:3], 3'b100};
    assign slot_next[1] = taken[1] ? target[1] : pc_seq;

    // slot 1 dropped after a taken slot 0, slot 0 dropped on an odd pc
    assign mask = {~taken[0] | pc_q[2], ~pc_q[2]};

    always_comb begin
        pc_next = pc_seq;
        if (taken[0] && !pc_q[2]) begin
            pc_next = target[0];
        end else if (taken[1]) begin
            pc_next = target[1];
        end
    end

    always_comb begin
        pkt_o.pc   = pc_q;
        pkt_o.mask = mask;
        for (int i = 0; i < 2; i++) begin
            pkt_o.predict_infos[i].target_pc   = target[i];
            pkt_o.predict_infos[i].next_pc     = slot_next[i];
            pkt_o.predict_infos[i].is_branch   = btb_rdata_i[i].is_branch;
            pkt_o.predict_infos[i].br_type     = btb_rdata_i[i].br_type;
            pkt_o.predict_infos[i].taken       = taken[i];
            pkt_o.predict_infos[i].scnt        = pht_rdata_i[i].scnt;
            pkt_o.predict_infos[i].need_update = ~tag_match[i]; // miss, back end must train
            pkt_o.predict_infos[i].history     = bht_rdata_i[i].history;
        end
    end

    assign pkt_valid_o = valid_q;

    // fetch addresses are word aligned
    a_redir_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) flush_i |-> (redir_addr_i[1:0] == 2'b00)
    );

endmodule

/* src/bpu_pkg.sv */
`include "bpu_config.svh"

package bpu_pkg;

    typedef enum logic [1:0] {
        BR_NORMAL = 2'b00, // conditional branch
        BR_JUMP   = 2'b01, // b / jirl not used as return
        BR_CALL   = 2'b10, // bl
        BR_RET    = 2'b11  // jirl back through ra
    } br_type_t;

    typedef struct packed {
        logic [31:0]             target_pc;
        logic [`BPU_TAG_LEN-1:0] tag;
        br_type_t                br_type;
        logic                    is_branch;
    } btb_entry_t;

    typedef struct packed {
        logic [`BPU_HISTORY_LEN-1:0] history;
    } bht_entry_t;

    typedef struct packed {
        logic [1:0] scnt; // 2-bit saturating counter
    } pht_entry_t;

    // feedback from the back end, one per slot
    typedef struct packed {
        logic                        update;
        logic [31:0]                 pc;
        logic [31:0]                 target_pc;
        logic                        taken;
        logic                        is_branch;
        br_type_t                    branch_type;
        logic                        type_miss;
        logic                        target_miss;
        logic [`BPU_HISTORY_LEN-1:0] history; // history seen at predict time
        logic [1:0]                  scnt;    // counter seen at predict time
    } correct_info_t;

    typedef struct packed {
        logic [31:0]                 target_pc;
        logic [31:0]                 next_pc;
        logic                        is_branch;
        br_type_t                    br_type;
        logic                        taken;
        logic [1:0]                  scnt;
        logic                        need_update; // no btb entry for this pc
        logic [`BPU_HISTORY_LEN-1:0] history;
    } predict_info_t;

    typedef struct packed {
        logic [31:0]            pc;
        logic [1:0]             mask;
        predict_info_t [1:0]    predict_infos;
    } fetch_pkt_t;

    // sized for the widest table, narrow tables use the low bits
    typedef struct packed {
        logic                    we;
        logic                    bank;
        logic [`BPU_PHT_LEN-1:0] addr;
    } table_wr_t;

    function automatic logic [`BPU_BTB_LEN-1:0] btb_hash(input logic [31:0] pc);
        return pc[17:9] ^ pc[11:3]; // fold high pc bits onto the word index
    endfunction

    function automatic logic [`BPU_TAG_LEN-1:0] pc_tag(input logic [31:0] pc);
        return pc[`BPU_TAG_LEN+11:12];
    endfunction

    function automatic logic [1:0] next_scnt(input logic [1:0] scnt, input logic taken);
        if (taken) begin
            return (scnt == 2'b11) ? 2'b11 : scnt + 2'd1;
        end
        return (scnt == 2'b00) ? 2'b00 : scnt - 2'd1;
    endfunction

endpackage

/* src/bpu_ras.sv */
`timescale 1ns/1ps

`include "bpu_config.svh"

module bpu_ras (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        push_i,
    input  logic        pop_i,
    input  logic [31:0] wdata_i, // return address to push
    output logic [31:0] top_o
);

    logic [31:0]             stack [`BPU_RAS_DEPTH];
    logic [`BPU_RAS_LEN-1:0] top_ptr; // points at the top entry
    logic [`BPU_RAS_LEN-1:0] w_ptr;   // next free slot, always top_ptr + 1

    initial begin
        for (int j = 0; j < `BPU_RAS_DEPTH; j++) begin
            stack[j] = '0;
        end
    end

    // stack contents, no reset
    always @(posedge clk) begin
        if (push_i) begin
            stack[w_ptr] <= wdata_i;
        end
    end

    // pointers wrap, overflow overwrites the oldest entry
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            top_ptr <= '1;
            w_ptr   <= '0;
        end else if (push_i) begin
            top_ptr <= w_ptr;
            w_ptr   <= w_ptr + 1'b1;
        end else if (pop_i) begin
            w_ptr   <= top_ptr;
            top_ptr <= top_ptr - 1'b1;
        end
    end

    assign top_o = stack[top_ptr];

    // a single correction is either a call or a return
    a_no_push_pop: assert property (
        @(posedge clk) disable iff (!rst_n) !(push_i && pop_i)
    );

endmodule

/* src/bpu_table.sv */
`timescale 1ns/1ps

module bpu_table #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 512,
    parameter int  AW      = 9
) (
    input  logic                      clk,
    input  bpu_pkg::table_wr_t        wr_i,
    input  entry_t                    wdata_i,
    input  logic [1:0][AW-1:0]        raddr_i, // one address per bank
    output entry_t [1:0]              rdata_o
);

    entry_t mem [2][DEPTH]; // two banks, one per slot

    // distributed ram powers up cleared
    initial begin
        for (int b = 0; b < 2; b++) begin
            for (int j = 0; j < DEPTH; j++) begin
                mem[b][j] = '0;
            end
        end
    end

    // single write port shared by both banks
    always @(posedge clk) begin
        if (wr_i.we) begin
            mem[wr_i.bank][wr_i.addr[AW-1:0]] <= wdata_i; // upper addr bits unused here
        end
    end

    // async read per bank
    for (genvar b = 0; b < 2; b++) begin : g_rd
        assign rdata_o[b] = mem[b][raddr_i[b]];
    end

    // decode must never hand over a write with an unknown index
    a_waddr_known: assert property (
        @(posedge clk) wr_i.we |-> !$isunknown({wr_i.bank, wr_i.addr[AW-1:0]})
    );

endmodule

/* src/bpu_top.sv */
`timescale 1ns/1ps

`include "bpu_config.svh"

module bpu_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         flush_i,
    input  logic [31:0]                  redir_addr_i,
    input  bpu_pkg::correct_info_t [1:0] correct_infos_i,
    output logic                         pkt_valid_o,
    output bpu_pkg::fetch_pkt_t          pkt_o,
    input  logic                         pkt_ready_i
);

    import bpu_pkg::*;

    // write side from decode
    table_wr_t                       btb_wr;
    table_wr_t                       bht_wr;
    table_wr_t                       pht_wr;
    btb_entry_t                      btb_wdata;
    bht_entry_t                      bht_wdata;
    pht_entry_t                      pht_wdata;
    logic                            ras_push;
    logic                            ras_pop;
    logic [31:0]                     ras_wdata;

    // read side to next-pc
    logic [`BPU_BTB_LEN-1:0]         btb_raddr;
    logic [1:0][`BPU_PHT_LEN-1:0]    pht_raddr;
    btb_entry_t [1:0]                btb_rdata;
    bht_entry_t [1:0]                bht_rdata;
    pht_entry_t [1:0]                pht_rdata;
    logic [31:0]                     ras_top;

    bpu_update_decode u_decode (
        .correct_infos_i (correct_infos_i),
        .btb_wr_o        (btb_wr),
        .btb_wdata_o     (btb_wdata),
        .bht_wr_o        (bht_wr),
        .bht_wdata_o     (bht_wdata),
        .pht_wr_o        (pht_wr),
        .pht_wdata_o     (pht_wdata),
        .ras_push_o      (ras_push),
        .ras_pop_o       (ras_pop),
        .ras_wdata_o     (ras_wdata)
    );

    // both banks read the same hashed index
    bpu_table #(.entry_t(btb_entry_t), .DEPTH(`BPU_BTB_DEPTH), .AW(`BPU_BTB_LEN)) u_btb (
        .clk (clk), .wr_i (btb_wr), .wdata_i (btb_wdata),
        .raddr_i ({2{btb_raddr}}), .rdata_o (btb_rdata)
    );

    bpu_table #(.entry_t(bht_entry_t), .DEPTH(`BPU_BTB_DEPTH), .AW(`BPU_BTB_LEN)) u_bht (
        .clk (clk), .wr_i (bht_wr), .wdata_i (bht_wdata),
        .raddr_i ({2{btb_raddr}}), .rdata_o (bht_rdata)
    );

    // per-bank index, each bank has its own history
    bpu_table #(.entry_t(pht_entry_t), .DEPTH(`BPU_PHT_DEPTH), .AW(`BPU_PHT_LEN)) u_pht (
        .clk (clk), .wr_i (pht_wr), .wdata_i (pht_wdata),
        .raddr_i (pht_raddr), .rdata_o (pht_rdata)
    );

    bpu_ras u_ras (
        .clk (clk), .rst_n (rst_n), .push_i (ras_push), .pop_i (ras_pop),
        .wdata_i (ras_wdata), .top_o (ras_top)
    );

    bpu_next_pc u_next_pc (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_i      (flush_i),
        .redir_addr_i (redir_addr_i),
        .btb_rdata_i  (btb_rdata),
        .bht_rdata_i  (bht_rdata),
        .pht_rdata_i  (pht_rdata),
        .ras_top_i    (ras_top),
        .btb_raddr_o  (btb_raddr),
        .pht_raddr_o  (pht_raddr),
        .pkt_valid_o  (pkt_valid_o),
        .pkt_o        (pkt_o),
        .pkt_ready_i  (pkt_ready_i)
    );

endmodule

/* src/bpu_update_decode.sv */
`timescale 1ns/1ps

`include "bpu_config.svh"

module bpu_update_decode (
    input  bpu_pkg::correct_info_t [1:0] correct_infos_i,
    output bpu_pkg::table_wr_t           btb_wr_o,
    output bpu_pkg::btb_entry_t          btb_wdata_o,
    output bpu_pkg::table_wr_t           bht_wr_o,
    output bpu_pkg::bht_entry_t          bht_wdata_o,
    output bpu_pkg::table_wr_t           pht_wr_o,
    output bpu_pkg::pht_entry_t          pht_wdata_o,
    output logic                         ras_push_o,
    output logic                         ras_pop_o,
    output logic [31:0]                  ras_wdata_o
);

    import bpu_pkg::*;

    correct_info_t               ci;      // the correction that trains this cycle
    logic [`BPU_BTB_LEN-1:0]     hash_idx;

    // first slot with update set wins
    assign ci       = correct_infos_i[0].update ? correct_infos_i[0] : correct_infos_i[1];
    assign hash_idx = btb_hash(ci.pc);

    always_comb begin
        // btb only rewritten when the stored entry was wrong
        btb_wr_o                   = '0;
        btb_wr_o.we                = ci.update & (ci.type_miss | ci.target_miss);
        btb_wr_o.bank              = ci.pc[2];
        btb_wr_o.addr[`BPU_BTB_LEN-1:0] = hash_idx;
        btb_wdata_o.target_pc      = ci.target_pc;
        btb_wdata_o.tag            = pc_tag(ci.pc);
        btb_wdata_o.br_type        = ci.branch_type;
        btb_wdata_o.is_branch      = ci.is_branch;

        // bht shares the btb index
        bht_wr_o                   = '0;
        bht_wr_o.we                = ci.update;
        bht_wr_o.bank              = ci.pc[2];
        bht_wr_o.addr[`BPU_BTB_LEN-1:0] = hash_idx;
        if (ci.type_miss) begin
            // new entry, restart history from this outcome
            bht_wdata_o.history = {{(`BPU_HISTORY_LEN-1){1'b0}}, ci.taken};
        end else begin
            bht_wdata_o.history = {ci.history[`BPU_HISTORY_LEN-2:0], ci.taken};
        end

        // pht indexed by the history the prediction used
        pht_wr_o.we                = ci.update;
        pht_wr_o.bank              = ci.pc[2];
        pht_wr_o.addr              = {ci.history, ci.pc[`BPU_PHT_PC_LEN+2:3]};
        pht_wdata_o.scnt           = next_scnt(ci.scnt, ci.taken);
    end

    assign ras_push_o  = ci.update && (ci.branch_type == BR_CALL);
    assign ras_pop_o   = ci.update && (ci.branch_type == BR_RET);
    assign ras_wdata_o = ci.pc + 32'd4; // return lands after the call

endmodule

/* verif/bpu_cases.txt */
# op rdy pc_or_redirect target type taken type_miss target_miss history scnt
# then expected packet: pc mask taken[1:0] next_pc need_update[1:0], all hex
step    1 0        0        0 0 0 0 00 0 1c000000 3 0 1c000008 0
step    1 0        0        0 0 0 0 00 0 1c000008 3 0 1c000010 0
stall   0 0        0        0 0 0 0 00 0 1c000010 3 0 1c000018 0
stall   0 0        0        0 0 0 0 00 0 1c000010 3 0 1c000018 0
flush   0 1c000104 0        0 0 0 0 00 0 1c000010 3 0 1c000018 0
stall   0 0        0        0 0 0 0 00 0 1c000104 2 0 1c000108 0
step    1 0        0        0 0 0 0 00 0 1c000104 2 0 1c000108 0
# jump at 1c000200 trained by a target miss
correct 0 1c000200 1c000400 1 1 0 1 00 0 1c000108 3 0 1c000110 0
flush   0 1c000200 0        0 0 0 0 00 0 1c000108 3 0 1c000110 0
step    1 0        0        0 0 0 0 00 0 1c000200 1 1 1c000400 0
step    1 0        0        0 0 0 0 00 0 1c000400 3 0 1c000408 0
# conditional in slot 1, taken once the counter under a stable history reaches 2
correct 0 1c000604 1c000800 0 1 1 0 00 0 1c000408 3 0 1c000410 0
flush   0 1c000600 0        0 0 0 0 00 0 1c000408 3 0 1c000410 0
correct 0 1c000604 1c000800 0 1 0 0 1f 1 1c000600 3 0 1c000608 0
step    1 0        0        0 0 0 0 00 0 1c000600 3 2 1c000800 0
step    1 0        0        0 0 0 0 00 0 1c000800 3 0 1c000808 0
# three calls, return entry trained (one pop), then a second pop
correct 0 1c001000 0        2 1 0 0 00 0 1c000808 3 0 1c000810 0
correct 0 1c001100 0        2 1 0 0 00 0 1c000808 3 0 1c000810 0
correct 0 1c001200 0        2 1 0 0 00 0 1c000808 3 0 1c000810 0
correct 0 1c003000 0        3 1 1 0 00 0 1c000808 3 0 1c000810 0
flush   0 1c003000 0        0 0 0 0 00 0 1c000808 3 0 1c000810 0
stall   0 0        0        0 0 0 0 00 0 1c003000 1 1 1c001104 2
correct 0 1c003000 0        3 1 0 0 00 0 1c003000 1 1 1c001104 2
step    1 0        0        0 0 0 0 00 0 1c003000 1 1 1c001004 2
step    1 0        0        0 0 0 0 00 0 1c001004 2 0 1c001008 3
# two updates in one cycle, only slot 0 trains
dual    0 1c005000 1c006000 1 1 1 0 00 0 1c001008 3 0 1c001010 3
flush   0 1c005000 0        0 0 0 0 00 0 1c001008 3 0 1c001010 3
step    1 0        0        0 0 0 0 00 0 1c005000 1 1 1c006000 2
step    1 0        0        0 0 0 0 00 0 1c006000 3 0 1c006008 3

/* verif/bpu_tb.sv */
`timescale 1ns/1ps

`include "bpu_config.svh"

module bpu_tb;

    import bpu_pkg::*;

    localparam logic [1:0] OP_IDLE  = 2'd0; // step or stall, only ready differs
    localparam logic [1:0] OP_FLUSH = 2'd1;
    localparam logic [1:0] OP_CORR  = 2'd2;
    localparam logic [1:0] OP_DUAL  = 2'd3; // both slots carry an update

    typedef struct packed {
        logic [1:0]  op;
        logic [31:0] rdy, a, b, ty, tk, tm, gm, hist, scnt; // a is redirect or branch pc
        logic [31:0] epc, emask, etk, enext, enu;          // packet seen before the edge
    } case_t;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                flush;
    logic [31:0]         redir_addr;
    correct_info_t [1:0] correct_infos;
    logic                pkt_valid;
    fetch_pkt_t          pkt;
    logic                pkt_ready;
    case_t               cases [$];
    integer              seed = 56;
    int                  errors = 0;
    int                  ncases = 0;
    logic                loaded = 1'b0;

    bpu_top bpu_top_inst (
        .clk (clk), .rst_n (rst_n), .flush_i (flush), .redir_addr_i (redir_addr),
        .correct_infos_i (correct_infos), .pkt_valid_o (pkt_valid), .pkt_o (pkt),
        .pkt_ready_i (pkt_ready)
    );

    always #4 clk = ~clk; // 8 ns period

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    // unselected slot, random payload with update low
    function automatic correct_info_t idle_info();
        logic [95:0]   bits;
        correct_info_t ci;
        bits      = {$random(seed), $random(seed), $random(seed)};
        ci        = bits[$bits(correct_info_t)-1:0];
        ci.update = 1'b0;
        return ci;
    endfunction

    task automatic load_cases();
        int          fd;
        int          n;
        string       op;
        string       rest;
        logic [31:0] f [14];
        logic [1:0]  code;
        case_t       c;
        fd = $fopen("verif/bpu_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open verif/bpu_cases.txt");
        end else begin
            while ($fscanf(fd, "%s", op) == 1) begin
                if (op.substr(0, 0) == "#") begin
                    n = $fgets(rest, fd); // rest of a comment line
                end else begin
                    n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1],
                                f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
                                f[12], f[13]);
                    code = (op == "flush") ? OP_FLUSH : (op == "correct") ? OP_CORR
                         : (op == "dual") ? OP_DUAL : OP_IDLE;
                    if (n == 14) begin
                        c = {code, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                             f[9], f[10], f[11], f[12], f[13]};
                        cases.push_back(c);
                    end else begin
                        errors++;
                        $display("case line for op %s has %0d fields instead of 14", op, n);
                    end
                end
            end
            $fclose(fd);
        end
        ncases = cases.size();
        loaded = 1'b1;
    endtask

    task automatic apply_case(input case_t c);
        correct_info_t ci;
        ci.update        = 1'b1;
        ci.pc            = c.a;
        ci.target_pc     = c.b;
        ci.taken         = c.tk[0];
        ci.is_branch     = 1'b1;
        ci.branch_type   = br_type_t'(c.ty[1:0]);
        ci.type_miss     = c.tm[0];
        ci.target_miss   = c.gm[0];
        ci.history       = c.hist[`BPU_HISTORY_LEN-1:0];
        ci.scnt          = c.scnt[1:0];
        pkt_ready        = c.rdy[0];
        flush            = (c.op == OP_FLUSH);
        redir_addr       = (c.op == OP_FLUSH) ? c.a : 32'd0;
        correct_infos[0] = (c.op == OP_CORR || c.op == OP_DUAL) ? ci : idle_info();
        correct_infos[1] = idle_info();
        if (c.op == OP_DUAL) begin
            ci.pc            = c.a + 32'd4; // neighbour slot, should lose arbitration
            correct_infos[1] = ci;
        end
    endtask

    task automatic check_packet(input case_t c);
        logic [1:0]  tk;
        logic [1:0]  nu;
        logic [31:0] nxt;
        tk  = {pkt.predict_infos[1].taken, pkt.predict_infos[0].taken};
        nu  = {pkt.predict_infos[1].need_update, pkt.predict_infos[0].need_update};
        // fetch goes on from the last live slot
        nxt = pkt.mask[1] ? pkt.predict_infos[1].next_pc : pkt.predict_infos[0].next_pc;
        check("pkt_valid_o", 32'd1, pkt_valid);
        check("pkt_o.pc", c.epc, pkt.pc);
        check("pkt_o.mask", c.emask, pkt.mask);
        check("taken", c.etk, tk);
        check("next_pc", c.enext, nxt);
        check("need_update", c.enu, nu);
    endtask

    initial begin
        int waited;
        rst_n         = 1'b0;
        flush         = 1'b0;
        redir_addr    = '0;
        pkt_ready     = 1'b0;
        correct_infos = '0;
        waited        = 0;
        load_cases();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check("pkt_valid_o", 32'd0, pkt_valid); // first cycle out of reset
        while (!pkt_valid && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        if (!pkt_valid) begin
            errors++;
            $display("packet valid never came up after reset");
        end
        // outputs checked at the falling edge, then next inputs driven
        for (int i = 0; i < ncases; i++) begin
            check_packet(cases[i]);
            apply_case(cases[i]);
            @(negedge clk);
        end
        $display("%0d errors in %0d cases", errors, ncases);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog, sized from the case count
    initial begin
        wait (loaded);
        #((ncases + 20) * 8);
        $display("timeout, case sequence did not finish within %0d ns", (ncases + 20) * 8);
        $display("Simulation FAILED");
        $finish;
    end

endmodule
